//--- hw/dcache_pkg.sv
// Geometry is fixed at 8 direct-mapped sets of 4 words, so resizing means editing the constants
package dcache_pkg;

    // --------------------
    // Geometry
    // --------------------
    localparam int word_w         = 32;
    localparam int words_per_line = 4;
    localparam int line_w         = word_w * words_per_line;  // 128 bits per line
    localparam int num_sets       = 8;

    // --------------------
    // Address split
    // --------------------
    // Processor addresses count words, not bytes
    localparam int proc_addr_w = 30;
    localparam int offset_w    = $clog2(words_per_line);  // Word within line
    localparam int index_w     = $clog2(num_sets);        // Set select
    localparam int tag_w       = proc_addr_w - offset_w - index_w;
    localparam int mem_addr_w  = proc_addr_w - offset_w;  // Memory counts whole lines

    // --------------------
    // Field types
    // --------------------
    typedef logic [word_w-1:0]      word_t;
    typedef logic [line_w-1:0]      line_t;
    typedef logic [proc_addr_w-1:0] proc_addr_t;
    typedef logic [mem_addr_w-1:0]  mem_addr_t;
    typedef logic [tag_w-1:0]       tag_t;
    typedef logic [index_w-1:0]     set_idx_t;
    typedef logic [offset_w-1:0]    word_off_t;

    // Miss handling states
    typedef enum logic [1:0] {
        st_idle       = 2'd0,  // Serving hits
        st_write_back = 2'd1,  // Dirty victim on its way out
        st_refill     = 2'd2   // Waiting for the requested line
    } cache_state_e;

endpackage

//--- hw/dcache_tag_store.sv
// Valid and dirty clear on reset but tags hold garbage until a set is first filled
module dcache_tag_store (
    input  logic                  clk,
    input  logic                  rst_n,
    input  dcache_pkg::proc_addr_t proc_addr,
    input  logic                  fill,
    input  logic                  write_hit,
    output logic                  hit,
    output logic                  victim_dirty,
    output dcache_pkg::tag_t      victim_tag
);

    import dcache_pkg::*;

    set_idx_t            set;
    tag_t                req_tag;
    logic [num_sets-1:0] valid;
    logic [num_sets-1:0] dirty;
    tag_t                tags [num_sets];

    // --------------------
    // Address split
    // --------------------
    assign set     = proc_addr[offset_w +: index_w];
    assign req_tag = proc_addr[proc_addr_w-1 -: tag_w];

    // --------------------
    // Lookup
    // --------------------
    assign hit          = valid[set] && (tags[set] == req_tag);
    assign victim_dirty = dirty[set];  // Only ever set on a valid line
    assign victim_tag   = tags[set];

    // --------------------
    // State bits
    // --------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= '0;
            dirty <= '0;
        end else if (fill) begin
            // Refilled line always starts clean
            valid[set] <= 1'b1;
            dirty[set] <= 1'b0;
        end else if (write_hit) begin
            dirty[set] <= 1'b1;
        end
    end

    // Tag only changes when a new line arrives
    always_ff @(posedge clk) begin
        if (fill) begin
            tags[set] <= req_tag;
        end
    end

endmodule

//--- hw/dcache_data_array.sv
// Line contents are undefined after reset, the tag store valid bits keep them from being used
module dcache_data_array (
    input  logic                   clk,
    input  dcache_pkg::proc_addr_t proc_addr,
    input  dcache_pkg::word_t      proc_wdata,
    input  logic                   write_hit,
    input  logic                   fill,
    input  dcache_pkg::line_t      mem_rdata,
    output dcache_pkg::word_t      proc_rdata,
    output dcache_pkg::line_t      victim_line
);

    import dcache_pkg::*;

    set_idx_t  set;
    word_off_t off;
    line_t     lines [num_sets];

    assign set = proc_addr[offset_w +: index_w];
    assign off = proc_addr[offset_w-1:0];

    // --------------------
    // Write port
    // --------------------
    always_ff @(posedge clk) begin
        if (fill) begin
            lines[set] <= mem_rdata;  // Whole line from memory
        end else if (write_hit) begin
            lines[set][off*word_w +: word_w] <= proc_wdata;
        end
    end

    // --------------------
    // Read ports
    // --------------------
    // Word for the processor, no added cycle on a hit
    assign proc_rdata = lines[set][off*word_w +: word_w];

    // Full line of the addressed set, sent out on write-back
    assign victim_line = lines[set];

endmodule

//--- hw/dcache_miss_ctrl.sv
// Processor must hold its request while stalled, and memory must answer with one-cycle mem_ready
module dcache_miss_ctrl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   proc_read,
    input  logic                   proc_write,
    input  dcache_pkg::proc_addr_t proc_addr,
    input  logic                   hit,
    input  logic                   victim_dirty,
    input  dcache_pkg::tag_t       victim_tag,
    input  dcache_pkg::line_t      victim_line,
    input  logic                   mem_ready,
    output logic                   proc_stall,
    output logic                   mem_read,
    output logic                   mem_write,
    output dcache_pkg::mem_addr_t  mem_addr,
    output dcache_pkg::line_t      mem_wdata,
    output logic                   write_hit,
    output logic                   fill
);

    import dcache_pkg::*;

    cache_state_e state;
    cache_state_e state_next;
    set_idx_t     set;
    mem_addr_t    req_line;
    logic         start_wb;    // Miss on a dirty set
    logic         start_rd;    // Refill request goes out next cycle

    assign set      = proc_addr[offset_w +: index_w];
    assign req_line = proc_addr[proc_addr_w-1:offset_w];

    // --------------------
    // Processor side
    // --------------------
    // Any request that misses holds the processor
    assign proc_stall = (proc_read || proc_write) && !hit;
    assign write_hit  = proc_write && hit;

    // Line lands in the array at the edge closing the ready cycle
    assign fill = (state == st_refill) && mem_ready;

    // --------------------
    // Next state
    // --------------------
    always_comb begin
        state_next = state;
        start_wb   = 1'b0;
        start_rd   = 1'b0;
        case (state)
            st_idle: begin
                if (proc_stall) begin
                    if (victim_dirty) begin
                        start_wb   = 1'b1;
                        state_next = st_write_back;
                    end else begin
                        start_rd   = 1'b1;
                        state_next = st_refill;
                    end
                end
            end
            st_write_back: begin
                if (mem_ready) begin
                    start_rd   = 1'b1;  // Victim accepted, fetch the new line
                    state_next = st_refill;
                end
            end
            st_refill: begin
                if (mem_ready) begin
                    state_next = st_idle;
                end
            end
            default: state_next = st_idle;
        endcase
    end

    // --------------------
    // Control registers
    // --------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= st_idle;
            mem_read  <= 1'b0;
            mem_write <= 1'b0;
        end else begin
            state     <= state_next;
            mem_write <= (state_next == st_write_back);
            mem_read  <= (state_next == st_refill);
        end
    end

    // Request payload, held steady until the next request starts
    always_ff @(posedge clk) begin
        if (start_wb) begin
            mem_addr  <= {victim_tag, set};  // Victim line address
            mem_wdata <= victim_line;
        end else if (start_rd) begin
            mem_addr <= req_line;
        end
    end

endmodule

//--- hw/dcache.sv
// Direct-mapped write-back data cache, one outstanding miss at a time and no byte enables
module dcache (
    input  logic                   clk,
    input  logic                   rst_n,
    // Processor port
    input  logic                   proc_read,
    input  logic                   proc_write,
    input  dcache_pkg::proc_addr_t proc_addr,
    input  dcache_pkg::word_t      proc_wdata,
    output dcache_pkg::word_t      proc_rdata,
    output logic                   proc_stall,
    // Memory port
    output logic                   mem_read,
    output logic                   mem_write,
    output dcache_pkg::mem_addr_t  mem_addr,
    output dcache_pkg::line_t      mem_wdata,
    input  dcache_pkg::line_t      mem_rdata,
    input  logic                   mem_ready
);

    import dcache_pkg::*;

    // --------------------
    // Internal wires
    // --------------------
    logic  hit;
    logic  victim_dirty;
    tag_t  victim_tag;
    line_t victim_line;
    logic  write_hit;
    logic  fill;

    dcache_tag_store u_tag_store (
        .clk          (clk),
        .rst_n        (rst_n),
        .proc_addr    (proc_addr),
        .fill         (fill),
        .write_hit    (write_hit),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    dcache_data_array u_data_array (
        .clk         (clk),
        .proc_addr   (proc_addr),
        .proc_wdata  (proc_wdata),
        .write_hit   (write_hit),
        .fill        (fill),
        .mem_rdata   (mem_rdata),
        .proc_rdata  (proc_rdata),
        .victim_line (victim_line)
    );

    dcache_miss_ctrl u_miss_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .proc_read    (proc_read),
        .proc_write   (proc_write),
        .proc_addr    (proc_addr),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .victim_line  (victim_line),
        .mem_ready    (mem_ready),
        .proc_stall   (proc_stall),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .write_hit    (write_hit),
        .fill         (fill)
    );

endmodule

//--- tb/dcache_props.sv
// Bound into dcache; covers the memory-side request rules and stall progress only
module dcache_props (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  proc_stall,
    input logic                  mem_read,
    input logic                  mem_write,
    input dcache_pkg::mem_addr_t mem_addr,
    input dcache_pkg::line_t     mem_wdata,
    input logic                  mem_ready
);

    timeunit 1ns;
    timeprecision 1ps;

    int error_count = 0;  // Failed assertions so far

    // --------------------
    // Memory port
    // --------------------
    a_single_req: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_read && mem_write))
    else begin
        $error("mem_read and mem_write high together");
        error_count++;
    end

    // Refill request holds until memory answers
    a_read_held: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_read && !mem_ready) |=> (mem_read && $stable(mem_addr)))
    else begin
        $error("refill request changed before mem_ready");
        error_count++;
    end

    a_write_held: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_write && !mem_ready) |=> (mem_write && $stable(mem_addr) && $stable(mem_wdata)))
    else begin
        $error("write-back request changed before mem_ready");
        error_count++;
    end

    // --------------------
    // Processor port
    // --------------------
    // A stall always has a memory transfer behind it
    a_stall_progress: assert property (@(posedge clk) disable iff (!rst_n)
        proc_stall |=> (!proc_stall || mem_read || mem_write))
    else begin
        $error("proc_stall held with no memory request");
        error_count++;
    end

endmodule

//--- tb/dcache_tb.sv
// Random regression over 64 lines of a fixed base, memory answers after 1 to 6 cycles
module dcache_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import dcache_pkg::*;

    // --------------------
    // Run parameters
    // --------------------
    localparam int          num_ops     = 2000;
    localparam int          clk_period  = 40;
    localparam int          num_lines   = 64;  // Eight lines compete for each set
    localparam int          min_latency = 1;
    localparam int          max_latency = 6;
    localparam mem_addr_t   mem_base    = 28'h5a3c400;
    localparam logic [31:0] seed        = 32'h595ccc8d;
    localparam longint      watchdog_ns = longint'(num_ops) * 20 * clk_period;

    logic       clk        = 1'b0;
    logic       rst_n      = 1'b0;
    logic       proc_read  = 1'b0;
    logic       proc_write = 1'b0;
    proc_addr_t proc_addr  = '0;
    word_t      proc_wdata = '0;
    word_t      proc_rdata;
    logic       proc_stall;
    logic       mem_read;
    logic       mem_write;
    mem_addr_t  mem_addr;
    line_t      mem_wdata;
    line_t      mem_rdata  = '0;
    logic       mem_ready  = 1'b0;

    // Memory model state
    line_t       mem_lines [num_lines];
    logic        mem_busy     = 1'b0;
    logic        req_is_write = 1'b0;
    int          req_idx      = 0;
    int          wait_cnt     = 0;
    logic [31:0] lat_rng      = ~seed;

    // Reference model and per-access expectations
    word_t       ref_words [num_lines*words_per_line];
    logic        sh_valid [num_sets];
    logic        sh_dirty [num_sets];
    tag_t        sh_tag   [num_sets];
    logic        exp_wb      = 1'b0;
    mem_addr_t   exp_wb_addr = '0;
    line_t       exp_wb_line = '0;
    mem_addr_t   exp_rd_addr = '0;
    int          wb_count    = 0;
    int          rd_count    = 0;
    logic [31:0] op_rng      = seed;
    logic [31:0] rnd;

    dcache dut (.*);

    bind dcache dcache_props u_props (.*);

    always #(clk_period/2) clk = ~clk;

    // --------------------
    // Helpers
    // --------------------
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Initial memory content, a different word for every address
    function automatic word_t init_word(input proc_addr_t a);
        return (word_t'(a) * 32'h9e3779b1) ^ 32'h5bd1e995;
    endfunction

    function automatic proc_addr_t word_addr(input int idx, input int off);
        mem_addr_t line;
        line = mem_base + mem_addr_t'(idx);
        return {line, word_off_t'(off)};
    endfunction

    function automatic line_t ref_line(input int idx);
        line_t l;
        for (int w = 0; w < words_per_line; w++) begin
            l[w*word_w +: word_w] = ref_words[idx*words_per_line + w];
        end
        return l;
    endfunction

    task automatic abort_run();
        $display("Regression failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic report_problem(input string why);
        $display("ERROR: %s", why);
        abort_run();
    endtask

    task automatic check_flag(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            $display("FAILED %s: got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string name);
        if (got !== exp) begin
            $display("FAILED %s: got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_line(input line_t got, input line_t exp, input string name);
        if (got !== exp) begin
            $display("FAILED %s: got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_line_addr(input mem_addr_t got, input mem_addr_t exp,
                                   input string name);
        if (got !== exp) begin
            $display("FAILED %s: got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    // --------------------
    // Memory model
    // --------------------
    task automatic accept_request();
        mem_addr_t rel;
        lat_rng  = xorshift(lat_rng);
        wait_cnt = min_latency + int'(lat_rng % (max_latency - min_latency + 1));
        rel      = mem_addr - mem_base;
        if (rel >= num_lines) begin
            report_problem("memory request outside the tested address range");
        end
        req_idx      = int'(rel);
        req_is_write = mem_write;
        mem_busy     = 1'b1;
        if (mem_write) begin
            wb_count++;
            if (!exp_wb) begin
                report_problem("write-back issued for a clean or invalid set");
            end
            check_line_addr(mem_addr, exp_wb_addr, "mem_addr");
            check_line(mem_wdata, exp_wb_line, "mem_wdata");
        end else begin
            rd_count++;
            if (exp_wb && wb_count == 0) begin
                report_problem("refill issued before the dirty victim was written back");
            end
            check_line_addr(mem_addr, exp_rd_addr, "mem_addr");
        end
    endtask

    // Sees the request levels from before the edge
    always @(posedge clk) begin
        if (!rst_n) begin
            mem_ready <= 1'b0;
            mem_busy  = 1'b0;
        end else if (mem_ready) begin
            mem_ready <= 1'b0;  // Exactly one cycle
            mem_busy  = 1'b0;
        end else if (!mem_busy && (mem_read || mem_write)) begin
            accept_request();
        end else if (mem_busy) begin
            wait_cnt = wait_cnt - 1;
            if (wait_cnt == 0) begin
                if (req_is_write) begin
                    mem_lines[req_idx] = mem_wdata;
                end else begin
                    mem_rdata <= mem_lines[req_idx];
                end
                mem_ready <= 1'b1;
            end
        end
    end

    // Protocol assertions in the bound checker
    always @(posedge clk) begin
        if (dut.u_props.error_count != 0) begin
            report_problem("bound assertions reported protocol errors");
        end
    end

    // --------------------
    // One processor access
    // --------------------
    task automatic run_op(input logic is_write, input int idx, input word_off_t off,
                          input word_t wdata);
        proc_addr_t addr;
        mem_addr_t  line;
        set_idx_t   set;
        tag_t       tag;
        logic       sh_hit;
        int         widx;
        addr = word_addr(idx, int'(off));
        line = addr[proc_addr_w-1:offset_w];
        set  = line[index_w-1:0];
        tag  = line[mem_addr_w-1:index_w];
        widx = idx*words_per_line + int'(off);
        @(posedge clk);
        proc_read  <= !is_write;
        proc_write <= is_write;
        proc_addr  <= addr;
        proc_wdata <= wdata;
        @(negedge clk);
        sh_hit      = sh_valid[set] && (sh_tag[set] == tag);
        exp_wb      = !sh_hit && sh_valid[set] && sh_dirty[set];
        exp_wb_addr = {sh_tag[set], set};
        exp_rd_addr = line;
        if (exp_wb) begin
            exp_wb_line = ref_line(int'(exp_wb_addr - mem_base));
        end
        wb_count = 0;
        rd_count = 0;
        check_flag(proc_stall, !sh_hit, "proc_stall");
        while (proc_stall) begin
            @(negedge clk);
        end
        if (wb_count != (exp_wb ? 1 : 0)) begin
            report_problem("wrong number of write-backs for this access");
        end
        if (rd_count != (sh_hit ? 0 : 1)) begin
            report_problem("wrong number of refills for this access");
        end
        if (!is_write) begin
            check_word(proc_rdata, ref_words[widx], "proc_rdata");
        end else begin
            ref_words[widx] = wdata;  // Lands at the next edge
        end
        sh_dirty[set] = (sh_hit && sh_dirty[set]) || is_write;
        sh_valid[set] = 1'b1;
        sh_tag[set]   = tag;
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        for (int i = 0; i < num_lines; i++) begin
            for (int w = 0; w < words_per_line; w++) begin
                ref_words[i*words_per_line + w] = init_word(word_addr(i, w));
            end
            mem_lines[i] = ref_line(i);
        end
        for (int s = 0; s < num_sets; s++) begin
            sh_valid[s] = 1'b0;
            sh_dirty[s] = 1'b0;
            sh_tag[s]   = '0;
        end
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_flag(mem_read, 1'b0, "mem_read");
        check_flag(mem_write, 1'b0, "mem_write");
        check_flag(proc_stall, 1'b0, "proc_stall");
        for (int op = 0; op < num_ops; op++) begin
            op_rng = xorshift(op_rng);
            rnd    = op_rng;
            op_rng = xorshift(op_rng);
            run_op(rnd[8], int'(rnd[31:16] % num_lines), rnd[7:6], op_rng);
        end
        @(posedge clk);
        proc_read  <= 1'b0;
        proc_write <= 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        if (dut.u_props.error_count == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            report_problem("bound assertions reported protocol errors");
        end
    end

    // Budget of 20 cycles per access covers even the worst dirty miss
    initial begin
        #(watchdog_ns);
        report_problem("watchdog expired before all accesses completed");
    end

endmodule

//--- files.f
hw/dcache_pkg.sv
hw/dcache_tag_store.sv
hw/dcache_data_array.sv
hw/dcache_miss_ctrl.sv
hw/dcache.sv
tb/dcache_props.sv
tb/dcache_tb.sv
